//--- verilog/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define WORD_W      32
`define REG_W       5
`define LINK_REG    31
`define PC_STEP     4

// primary opcodes
`define OP_SPECIAL  6'b00_0000
`define OP_REGIMM   6'b00_0001
`define OP_J        6'b00_0010
`define OP_JAL      6'b00_0011
`define OP_BEQ      6'b00_0100
`define OP_BNE      6'b00_0101
`define OP_BLEZ     6'b00_0110
`define OP_BGTZ     6'b00_0111
`define OP_ADDI     6'b00_1000
`define OP_ADDIU    6'b00_1001
`define OP_SLTI     6'b00_1010
`define OP_SLTIU    6'b00_1011
`define OP_ANDI     6'b00_1100
`define OP_ORI      6'b00_1101
`define OP_XORI     6'b00_1110
`define OP_LUI      6'b00_1111
`define OP_LB       6'b10_0000
`define OP_LH       6'b10_0001
`define OP_LW       6'b10_0011
`define OP_LBU      6'b10_0100
`define OP_LHU      6'b10_0101
`define OP_SB       6'b10_1000
`define OP_SH       6'b10_1001
`define OP_SW       6'b10_1011

// funct codes under SPECIAL
`define FN_SLL      6'b00_0000
`define FN_SRL      6'b00_0010
`define FN_SRA      6'b00_0011
`define FN_SLLV     6'b00_0100
`define FN_SRLV     6'b00_0110
`define FN_SRAV     6'b00_0111
`define FN_JR       6'b00_1000
`define FN_JALR     6'b00_1001
`define FN_SYSCALL  6'b00_1100
`define FN_BREAK    6'b00_1101
`define FN_ADD      6'b10_0000
`define FN_ADDU     6'b10_0001
`define FN_SUB      6'b10_0010
`define FN_SUBU     6'b10_0011
`define FN_AND      6'b10_0100
`define FN_OR       6'b10_0101
`define FN_XOR      6'b10_0110
`define FN_NOR      6'b10_0111
`define FN_SLT      6'b10_1010
`define FN_SLTU     6'b10_1011

// rt codes under REGIMM
`define RT_BLTZ     5'b0_0000
`define RT_BGEZ     5'b0_0001
`define RT_BLTZAL   5'b1_0000
`define RT_BGEZAL   5'b1_0001

`endif

//--- verilog/id_pkg.sv
`default_nettype none

`include "id_defs.svh"

package id_pkg;

    typedef struct packed {
        logic is_add, is_addi, is_addu, is_addiu;
        logic is_sub, is_subu, is_slt, is_slti;
        logic is_sltu, is_sltiu, is_and, is_andi;
        logic is_lui, is_nor, is_or, is_ori;
        logic is_xor, is_xori, is_sllv, is_sll;
        logic is_srav, is_sra, is_srlv, is_srl;
        logic is_beq, is_bne, is_bgez, is_bgtz;
        logic is_blez, is_bltz, is_bgezal, is_bltzal;
        logic is_j, is_jal, is_jr, is_jalr;
        logic is_lb, is_lbu, is_lh, is_lhu;
        logic is_lw, is_sb, is_sh, is_sw;
        logic is_syscall, is_break;
    } inst_dec_t;

    // one-hot, add in the top bit
    typedef struct packed {
        logic op_add, op_sub, op_slt, op_sltu;
        logic op_and, op_nor, op_or, op_xor;
        logic op_sll, op_srl, op_sra, op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa_zext;
        logic pc;
        logic rs;
    } src1_sel_t;

    typedef struct packed {
        logic imm_zext;
        logic const8;
        logic imm_sext;
        logic rt;
    } src2_sel_t;

    typedef struct packed {
        logic lb, lbu, lh, lhu;
        logic lw, sb, sh, sw;
    } mem_op_t;

    typedef struct packed {
        logic [`REG_W-1:0] code;
        logic pc_misaligned;
        logic syscall;
        logic brk;
        logic reserved;
    } exc_t;

    typedef struct packed {
        exc_t exc;
        mem_op_t mem_op;
        alu_op_t alu_op;
        src1_sel_t src1;
        src2_sel_t src2;
        logic ram_en;
        logic ram_wen;
        logic rf_we;
        logic [`REG_W-1:0] rf_waddr;
        logic sel_rf_res;
    } ex_ctrl_t;

    typedef struct packed {
        logic taken;
        logic [`WORD_W-1:0] target;
    } br_bus_t;

endpackage

`default_nettype wire

//--- verilog/inst_recognizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module inst_recognizer (
    input  wire [`WORD_W-1:0] inst,
    output id_pkg::inst_dec_t dec
);

    wire [5:0] opcode = inst[31:26];
    wire [4:0] rs     = inst[25:21];
    wire [4:0] rt     = inst[20:16];
    wire [4:0] rd     = inst[15:11];
    wire [4:0] sa     = inst[10:6];
    wire [5:0] funct  = inst[5:0];

    wire special = (opcode == `OP_SPECIAL);
    wire regimm  = (opcode == `OP_REGIMM);

    // register forms need sa == 0
    wire rr = special & (sa == 5'd0);
    // immediate shifts need rs == 0
    wire ish = special & (rs == 5'd0);
    // jr/jalr need rt and sa clear, jr also rd
    wire jreg = special & (rt == 5'd0) & (sa == 5'd0);

    always_comb begin
        dec.is_add     = rr & (funct == `FN_ADD);
        dec.is_addu    = rr & (funct == `FN_ADDU);
        dec.is_sub     = rr & (funct == `FN_SUB);
        dec.is_subu    = rr & (funct == `FN_SUBU);
        dec.is_slt     = rr & (funct == `FN_SLT);
        dec.is_sltu    = rr & (funct == `FN_SLTU);
        dec.is_and     = rr & (funct == `FN_AND);
        dec.is_nor     = rr & (funct == `FN_NOR);
        dec.is_or      = rr & (funct == `FN_OR);
        dec.is_xor     = rr & (funct == `FN_XOR);
        dec.is_sllv    = rr & (funct == `FN_SLLV);
        dec.is_srlv    = rr & (funct == `FN_SRLV);
        dec.is_srav    = rr & (funct == `FN_SRAV);
        dec.is_sll     = ish & (funct == `FN_SLL);
        dec.is_srl     = ish & (funct == `FN_SRL);
        dec.is_sra     = ish & (funct == `FN_SRA);

        dec.is_addi    = (opcode == `OP_ADDI);
        dec.is_addiu   = (opcode == `OP_ADDIU);
        dec.is_slti    = (opcode == `OP_SLTI);
        dec.is_sltiu   = (opcode == `OP_SLTIU);
        dec.is_andi    = (opcode == `OP_ANDI);
        dec.is_ori     = (opcode == `OP_ORI);
        dec.is_xori    = (opcode == `OP_XORI);
        dec.is_lui     = (opcode == `OP_LUI);

        dec.is_beq     = (opcode == `OP_BEQ);
        dec.is_bne     = (opcode == `OP_BNE);
        dec.is_bgtz    = (opcode == `OP_BGTZ) & (rt == 5'd0);
        dec.is_blez    = (opcode == `OP_BLEZ) & (rt == 5'd0);
        dec.is_bltz    = regimm & (rt == `RT_BLTZ);
        dec.is_bgez    = regimm & (rt == `RT_BGEZ);
        dec.is_bltzal  = regimm & (rt == `RT_BLTZAL);
        dec.is_bgezal  = regimm & (rt == `RT_BGEZAL);
        dec.is_j       = (opcode == `OP_J);
        dec.is_jal     = (opcode == `OP_JAL);
        dec.is_jr      = jreg & (rd == 5'd0) & (funct == `FN_JR);
        dec.is_jalr    = jreg & (funct == `FN_JALR);

        dec.is_lb      = (opcode == `OP_LB);
        dec.is_lbu     = (opcode == `OP_LBU);
        dec.is_lh      = (opcode == `OP_LH);
        dec.is_lhu     = (opcode == `OP_LHU);
        dec.is_lw      = (opcode == `OP_LW);
        dec.is_sb      = (opcode == `OP_SB);
        dec.is_sh      = (opcode == `OP_SH);
        dec.is_sw      = (opcode == `OP_SW);

        // code field is free for these two
        dec.is_syscall = special & (funct == `FN_SYSCALL);
        dec.is_break   = special & (funct == `FN_BREAK);
    end

endmodule

`default_nettype wire

//--- verilog/ctrl_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module ctrl_gen (
    input  wire [`WORD_W-1:0]  inst,
    input  wire [`WORD_W-1:0]  pc,
    input  wire id_pkg::inst_dec_t dec,
    output id_pkg::ex_ctrl_t   ctrl
);

    wire [`REG_W-1:0] rt = inst[20:16];
    wire [`REG_W-1:0] rd = inst[15:11];

    wire is_load  = dec.is_lb | dec.is_lbu | dec.is_lh | dec.is_lhu | dec.is_lw;
    wire is_store = dec.is_sb | dec.is_sh | dec.is_sw;
    wire is_link  = dec.is_jal | dec.is_jalr | dec.is_bltzal | dec.is_bgezal;
    wire is_ishft = dec.is_sll | dec.is_srl | dec.is_sra;

    // result goes to rd
    wire rd_dst = dec.is_add | dec.is_addu | dec.is_sub | dec.is_subu
                | dec.is_slt | dec.is_sltu | dec.is_and | dec.is_nor
                | dec.is_or  | dec.is_xor  | dec.is_sllv | dec.is_srlv
                | dec.is_srav | is_ishft;

    // result goes to rt
    wire rt_dst = dec.is_addi | dec.is_addiu | dec.is_slti | dec.is_sltiu
                | dec.is_andi | dec.is_ori | dec.is_xori | dec.is_lui | is_load;

    always_comb begin
        ctrl.alu_op.op_add  = dec.is_add | dec.is_addu | dec.is_addi | dec.is_addiu
                            | is_link | is_load | is_store;
        ctrl.alu_op.op_sub  = dec.is_sub | dec.is_subu;
        ctrl.alu_op.op_slt  = dec.is_slt | dec.is_slti;
        ctrl.alu_op.op_sltu = dec.is_sltu | dec.is_sltiu;
        ctrl.alu_op.op_and  = dec.is_and | dec.is_andi;
        ctrl.alu_op.op_nor  = dec.is_nor;
        ctrl.alu_op.op_or   = dec.is_or | dec.is_ori;
        ctrl.alu_op.op_xor  = dec.is_xor | dec.is_xori;
        ctrl.alu_op.op_sll  = dec.is_sll | dec.is_sllv;
        ctrl.alu_op.op_srl  = dec.is_srl | dec.is_srlv;
        ctrl.alu_op.op_sra  = dec.is_sra | dec.is_srav;
        ctrl.alu_op.op_lui  = dec.is_lui;

        // lui takes no first operand
        ctrl.src1.rs      = (rd_dst & ~is_ishft) | (rt_dst & ~dec.is_lui) | is_store;
        ctrl.src1.pc      = is_link;
        ctrl.src1.sa_zext = is_ishft;

        ctrl.src2.rt       = rd_dst;
        ctrl.src2.imm_sext = dec.is_addi | dec.is_addiu | dec.is_slti | dec.is_sltiu
                           | dec.is_lui | is_load | is_store;
        // link value is pc + 8
        ctrl.src2.const8   = is_link;
        ctrl.src2.imm_zext = dec.is_andi | dec.is_ori | dec.is_xori;

        ctrl.mem_op = {dec.is_lb, dec.is_lbu, dec.is_lh, dec.is_lhu,
                       dec.is_lw, dec.is_sb, dec.is_sh, dec.is_sw};
        ctrl.ram_en     = is_load | is_store;
        ctrl.ram_wen    = is_store;
        ctrl.sel_rf_res = is_load;

        ctrl.rf_we    = rd_dst | rt_dst | is_link;
        ctrl.rf_waddr = ({`REG_W{rd_dst}} & rd)
                      | ({`REG_W{rt_dst}} & rt)
                      | ({`REG_W{is_link}} & `REG_W'(`LINK_REG));

        ctrl.exc.code          = rd;
        ctrl.exc.pc_misaligned = (pc[1:0] != 2'b00);
        ctrl.exc.syscall       = dec.is_syscall;
        ctrl.exc.brk           = dec.is_break;
        // nothing recognized, dropped opcodes land here too
        ctrl.exc.reserved      = ~(|dec);
    end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module branch_unit (
    input  wire                id_valid,
    input  wire [`WORD_W-1:0]  inst,
    input  wire [`WORD_W-1:0]  pc,
    input  wire [`WORD_W-1:0]  rdata1,
    input  wire [`WORD_W-1:0]  rdata2,
    input  wire id_pkg::inst_dec_t dec,
    output id_pkg::br_bus_t    br_bus,
    output logic               delay_slot
);

    wire [`WORD_W-1:0] pc_plus4 = pc + `PC_STEP;
    wire [`WORD_W-1:0] offset   = {{(`WORD_W-18){inst[15]}}, inst[15:0], 2'b00};

    wire rs_eq_rt = (rdata1 == rdata2);
    wire rs_lt_z  = rdata1[`WORD_W-1];
    wire rs_eq_z  = (rdata1 == '0);

    wire cond_br = dec.is_beq | dec.is_bne | dec.is_bgez | dec.is_bgtz
                 | dec.is_blez | dec.is_bltz | dec.is_bgezal | dec.is_bltzal;
    wire abs_jmp = dec.is_j | dec.is_jal;
    wire reg_jmp = dec.is_jr | dec.is_jalr;

    wire cond_ok = (dec.is_beq & rs_eq_rt)
                 | (dec.is_bne & ~rs_eq_rt)
                 | ((dec.is_bgez | dec.is_bgezal) & ~rs_lt_z)
                 | ((dec.is_bltz | dec.is_bltzal) & rs_lt_z)
                 | (dec.is_bgtz & ~rs_lt_z & ~rs_eq_z)
                 | (dec.is_blez & (rs_lt_z | rs_eq_z));

    always_comb begin
        br_bus.taken = id_valid & (abs_jmp | reg_jmp | cond_ok);

        if (cond_br) begin
            br_bus.target = pc_plus4 + offset;
        end else if (abs_jmp) begin
            // region of the current pc
            br_bus.target = {pc[`WORD_W-1:`WORD_W-4], inst[25:0], 2'b00};
        end else if (reg_jmp) begin
            br_bus.target = rdata1;
        end else begin
            br_bus.target = '0;
        end

        delay_slot = id_valid & (cond_br | abs_jmp | reg_jmp);
    end

endmodule

`default_nettype wire

//--- verilog/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_ex_reg (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 id_valid,
    input  wire [`WORD_W-1:0]   inst,
    input  wire id_pkg::ex_ctrl_t id_ctrl,
    output logic                ex_valid,
    output id_pkg::ex_ctrl_t    ex_ctrl,
    output logic                load_stall
);

    wire [`REG_W-1:0] rs = inst[25:21];
    wire [`REG_W-1:0] rt = inst[20:16];

    // held load writes a register the new instruction reads
    wire dep = (ex_ctrl.rf_waddr == rs) | (ex_ctrl.rf_waddr == rt);

    assign load_stall = id_valid & ex_valid & ex_ctrl.sel_rf_res & dep;

    wire accept = id_valid & ~load_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid        <= 1'b0;
            ex_ctrl.rf_we   <= 1'b0;
            ex_ctrl.ram_en  <= 1'b0;
            ex_ctrl.ram_wen <= 1'b0;
        end else begin
            // bubble when stalled or idle, word stays put
            ex_valid <= accept;
            if (accept) begin
                ex_ctrl <= id_ctrl;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  id_valid,
    input  wire [`WORD_W-1:0]    inst,
    input  wire [`WORD_W-1:0]    pc,
    input  wire [`WORD_W-1:0]    rdata1,
    input  wire [`WORD_W-1:0]    rdata2,
    output wire id_pkg::br_bus_t  br_bus,
    output wire                  delay_slot,
    output wire                  load_stall,
    output wire                  ex_valid,
    output wire id_pkg::ex_ctrl_t ex_ctrl
);

    import id_pkg::*;

    wire inst_dec_t dec;
    wire ex_ctrl_t  id_ctrl;

    inst_recognizer u_inst_recognizer (
        .inst (inst),
        .dec  (dec)
    );

    ctrl_gen u_ctrl_gen (
        .inst (inst),
        .pc   (pc),
        .dec  (dec),
        .ctrl (id_ctrl)
    );

    branch_unit u_branch_unit (
        .id_valid   (id_valid),
        .inst       (inst),
        .pc         (pc),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .dec        (dec),
        .br_bus     (br_bus),
        .delay_slot (delay_slot)
    );

    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .rst        (rst),
        .id_valid   (id_valid),
        .inst       (inst),
        .id_ctrl    (id_ctrl),
        .ex_valid   (ex_valid),
        .ex_ctrl    (ex_ctrl),
        .load_stall (load_stall)
    );

endmodule

`default_nettype wire

//--- sim/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   chk_en,
    input  wire [7:0]             idx,
    input  wire id_pkg::br_bus_t  exp_br,
    input  wire                   exp_ds,
    input  wire                   exp_stall,
    input  wire id_pkg::ex_ctrl_t exp_ctrl,
    input  wire                   report_req,
    input  wire id_pkg::br_bus_t  br_bus,
    input  wire                   delay_slot,
    input  wire                   load_stall,
    input  wire                   ex_valid,
    input  wire id_pkg::ex_ctrl_t ex_ctrl,
    output logic                  report_done,
    output int                    errors
);

    import id_pkg::*;

    int       tests;
    int       held_idx;
    logic     exp_ev;
    logic     entry_bad;
    ex_ctrl_t held_ctrl;

    task automatic flag(input int n, input string msg);
        $display("ERROR %0t ns: entry %0d %s", $time, n, msg);
        errors++;
        entry_bad = 1'b1;
    endtask

    initial begin
        errors      = 0;
        tests       = 0;
        held_idx    = 0;
        exp_ev      = 1'b0;
        entry_bad   = 1'b0;
        held_ctrl   = '0;
        report_done = 1'b0;
    end

    // sample mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst && {ex_ctrl.rf_we, ex_ctrl.ram_en, ex_ctrl.ram_wen} !== 3'b000) begin
            $display("ERROR %0t ns: ex_ctrl enables set during reset", $time);
            errors++;
        end
        if (ex_valid !== exp_ev)
            flag(held_idx, $sformatf("ex_valid %b, expected %b", ex_valid, exp_ev));
        if (exp_ev) begin
            if (ex_ctrl !== held_ctrl)
                flag(held_idx, $sformatf("ex_ctrl %h, expected %h", ex_ctrl, held_ctrl));
            tests++;
            $display("entry %0d: %s", held_idx, entry_bad ? "FAIL" : "ok");
            entry_bad = 1'b0;
        end
        if (chk_en) begin
            if (br_bus !== exp_br)
                flag(idx, $sformatf("br_bus %h, expected %h", br_bus, exp_br));
            if (delay_slot !== exp_ds)
                flag(idx, $sformatf("delay_slot %b, expected %b", delay_slot, exp_ds));
            if (load_stall !== exp_stall)
                flag(idx, $sformatf("load_stall %b, expected %b", load_stall, exp_stall));
        end
        exp_ev = chk_en & ~exp_stall & ~rst;
        if (exp_ev) begin
            held_ctrl = exp_ctrl;
            held_idx  = idx;
        end
        if (report_req && !report_done) begin
            $display("checked %0d entries, %0d errors", tests, errors);
            report_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module tb_id_stage;

    import id_pkg::*;

    typedef struct packed {
        logic [`WORD_W-1:0] inst;
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] rdata1;
        logic [`WORD_W-1:0] rdata2;
        logic               stall;
        br_bus_t            br;
        logic               ds;
        ex_ctrl_t           ctrl;
    } entry_t;

    localparam int MAX_ENTRIES = 64;

    entry_t             stim [MAX_ENTRIES];
    int                 n_entries;
    logic               clk, rst, id_valid;
    logic [`WORD_W-1:0] inst, pc, rdata1, rdata2;
    br_bus_t            br_bus, exp_br;
    ex_ctrl_t           ex_ctrl, exp_ctrl;
    logic               delay_slot, load_stall, ex_valid;
    logic               chk_en, exp_stall, exp_ds, report_req, report_done;
    logic [7:0]         idx;
    int                 errors;

    id_stage u_id_stage (
        .clk (clk), .rst (rst), .id_valid (id_valid), .inst (inst), .pc (pc),
        .rdata1 (rdata1), .rdata2 (rdata2), .br_bus (br_bus), .delay_slot (delay_slot),
        .load_stall (load_stall), .ex_valid (ex_valid), .ex_ctrl (ex_ctrl)
    );

    id_checker u_id_checker (
        .clk (clk), .rst (rst), .chk_en (chk_en), .idx (idx), .exp_br (exp_br),
        .exp_ds (exp_ds), .exp_stall (exp_stall), .exp_ctrl (exp_ctrl),
        .report_req (report_req), .br_bus (br_bus), .delay_slot (delay_slot),
        .load_stall (load_stall), .ex_valid (ex_valid), .ex_ctrl (ex_ctrl),
        .report_done (report_done), .errors (errors)
    );

    // fl is {ram_en, ram_wen, rf_we, sel_rf_res}, ex is {misaligned, syscall, break, reserved}
    function automatic ex_ctrl_t make_ctrl(input logic [11:0] alu, input logic [2:0] s1,
                                           input logic [3:0] s2, input logic [7:0] mem,
                                           input logic [3:0] fl, input logic [4:0] wa,
                                           input logic [3:0] ex);
        ex_ctrl_t c;
        c.alu_op   = alu;
        c.src1     = s1;
        c.src2     = s2;
        c.mem_op   = mem;
        c.rf_waddr = wa;
        c.exc.code = '0;
        {c.ram_en, c.ram_wen, c.rf_we, c.sel_rf_res} = fl;
        {c.exc.pc_misaligned, c.exc.syscall, c.exc.brk, c.exc.reserved} = ex;
        return c;
    endfunction

    task automatic add(input logic [31:0] i, p, a, b, input logic st, tk,
                       input logic [31:0] tg, input logic d, input ex_ctrl_t c);
        entry_t e;
        e.inst      = i;
        e.pc        = p;
        e.rdata1    = a;
        e.rdata2    = b;
        e.stall     = st;
        e.br.taken  = tk;
        e.br.target = tg;
        e.ds        = d;
        e.ctrl      = c;
        // code slot carries the rd field
        e.ctrl.exc.code = i[15:11];
        stim[n_entries] = e;
        n_entries++;
    endtask

    task automatic alu_entry(input logic [31:0] i, input logic [11:0] op, input logic [2:0] s1,
                             input logic [3:0] s2, input logic [4:0] wa, input logic st);
        add(i, 32'h0040_0000, 32'h1, 32'h2, st, 1'b0, '0, 1'b0,
            make_ctrl(op, s1, s2, 8'h00, 4'b0010, wa, 4'h0));
    endtask

    task automatic br_entry(input logic [31:0] i, p, a, b, input logic tk,
                            input logic [31:0] tg, input ex_ctrl_t c);
        add(i, p, a, b, 1'b0, tk, tg, 1'b1, c);
    endtask

    task automatic mem_entry(input logic [31:0] i, input logic [7:0] mem,
                             input logic [3:0] fl, input logic [4:0] wa);
        add(i, 32'h0040_0200, 32'h1, 32'h2, 1'b0, 1'b0, '0, 1'b0,
            make_ctrl(12'h800, 3'd1, 4'h2, mem, fl, wa, 4'h0));
    endtask

    task automatic exc_entry(input logic [31:0] i, input logic [3:0] ex);
        add(i, 32'h0040_0000, '0, '0, 1'b0, 1'b0, '0, 1'b0,
            make_ctrl(12'h0, 3'd0, 4'h0, 8'h00, 4'h0, 5'd0, ex));
    endtask

    task automatic build_table();
        ex_ctrl_t nc;
        ex_ctrl_t lk;
        nc = '0;
        lk = make_ctrl(12'h800, 3'd2, 4'h4, 8'h00, 4'b0010, 5'd31, 4'h0);
        alu_entry(32'h0022_1820, 12'h800, 3'd1, 4'h1, 5'd3, 1'b0);
        alu_entry(32'h00A6_2022, 12'h400, 3'd1, 4'h1, 5'd4, 1'b0);
        alu_entry(32'h0022_382A, 12'h200, 3'd1, 4'h1, 5'd7, 1'b0);
        alu_entry(32'h0022_4027, 12'h040, 3'd1, 4'h1, 5'd8, 1'b0);
        alu_entry(32'h0022_4804, 12'h008, 3'd1, 4'h1, 5'd9, 1'b0);
        alu_entry(32'h0002_5100, 12'h008, 3'd4, 4'h1, 5'd10, 1'b0);
        alu_entry(32'h0002_58C3, 12'h002, 3'd4, 4'h1, 5'd11, 1'b0);
        alu_entry(32'h2425_FFFF, 12'h800, 3'd1, 4'h2, 5'd5, 1'b0);
        alu_entry(32'h3026_00FF, 12'h080, 3'd1, 4'h8, 5'd6, 1'b0);
        alu_entry(32'h2C27_0005, 12'h100, 3'd1, 4'h2, 5'd7, 1'b0);
        alu_entry(32'h3C0C_1234, 12'h001, 3'd0, 4'h2, 5'd12, 1'b0);
        // forward branches land on 0x00400114, backward ones on 0x004000fc
        br_entry(32'h1022_0004, 32'h0040_0100, 32'd5, 32'd5, 1'b1, 32'h0040_0114, nc);
        br_entry(32'h1022_0004, 32'h0040_0100, 32'd5, 32'd6, 1'b0, 32'h0040_0114, nc);
        br_entry(32'h1422_0004, 32'h0040_0100, 32'd5, 32'd6, 1'b1, 32'h0040_0114, nc);
        br_entry(32'h1422_0004, 32'h0040_0100, 32'd5, 32'd5, 1'b0, 32'h0040_0114, nc);
        br_entry(32'h0421_FFFE, 32'h0040_0100, 32'h0, 32'h0, 1'b1, 32'h0040_00FC, nc);
        br_entry(32'h0421_FFFE, 32'h0040_0100, 32'h8000_0000, 32'h0, 1'b0, 32'h0040_00FC, nc);
        br_entry(32'h0420_FFFE, 32'h0040_0100, 32'h8000_0000, 32'h0, 1'b1, 32'h0040_00FC, nc);
        br_entry(32'h0420_FFFE, 32'h0040_0100, 32'h1, 32'h0, 1'b0, 32'h0040_00FC, nc);
        br_entry(32'h1C20_0004, 32'h0040_0100, 32'h1, 32'h0, 1'b1, 32'h0040_0114, nc);
        br_entry(32'h1C20_0004, 32'h0040_0100, 32'h0, 32'h0, 1'b0, 32'h0040_0114, nc);
        br_entry(32'h1820_0004, 32'h0040_0100, 32'h0, 32'h0, 1'b1, 32'h0040_0114, nc);
        br_entry(32'h1820_0004, 32'h0040_0100, 32'h1, 32'h0, 1'b0, 32'h0040_0114, nc);
        br_entry(32'h0431_0004, 32'h0040_0100, 32'h0, 32'h0, 1'b1, 32'h0040_0114, lk);
        br_entry(32'h0431_0004, 32'h0040_0100, 32'hFFFF_FFFF, 32'h0, 1'b0, 32'h0040_0114, lk);
        br_entry(32'h0430_0004, 32'h0040_0100, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'h0040_0114, lk);
        br_entry(32'h0430_0004, 32'h0040_0100, 32'h0, 32'h0, 1'b0, 32'h0040_0114, lk);
        br_entry(32'h0810_0040, 32'h1040_0100, 32'h0, 32'h0, 1'b1, 32'h1040_0100, nc);
        br_entry(32'h0C10_0040, 32'h1040_0100, 32'h0, 32'h0, 1'b1, 32'h1040_0100, lk);
        br_entry(32'h0020_0008, 32'h0040_0100, 32'h0040_0200, 32'h0, 1'b1, 32'h0040_0200, nc);
        br_entry(32'h0020_F809, 32'h0040_0100, 32'h0040_0300, 32'h0, 1'b1, 32'h0040_0300, lk);
        mem_entry(32'h8C28_0004, 8'h08, 4'b1011, 5'd8);
        mem_entry(32'h8029_0000, 8'h80, 4'b1011, 5'd9);
        mem_entry(32'h942A_0000, 8'h10, 4'b1011, 5'd10);
        mem_entry(32'hAC22_0008, 8'h01, 4'b1100, 5'd0);
        mem_entry(32'hA022_0000, 8'h04, 4'b1100, 5'd0);
        // load to r8, then readers of r8 as rs and as rt, then an independent one
        mem_entry(32'h8C28_0000, 8'h08, 4'b1011, 5'd8);
        alu_entry(32'h0102_1820, 12'h800, 3'd1, 4'h1, 5'd3, 1'b1);
        mem_entry(32'h8C28_0000, 8'h08, 4'b1011, 5'd8);
        alu_entry(32'h0048_1820, 12'h800, 3'd1, 4'h1, 5'd3, 1'b1);
        mem_entry(32'h8C28_0000, 8'h08, 4'b1011, 5'd8);
        alu_entry(32'h0022_2025, 12'h020, 3'd1, 4'h1, 5'd4, 1'b0);
        exc_entry(32'h0000_000C, 4'b0100);
        exc_entry(32'h0000_000D, 4'b0010);
        exc_entry(32'h0022_0018, 4'b0001);
        exc_entry(32'hFC00_0000, 4'b0001);
        add(32'h2425_FFFF, 32'h0040_0302, 32'h1, 32'h2, 1'b0, 1'b0, '0, 1'b0,
            make_ctrl(12'h800, 3'd1, 4'h2, 8'h00, 4'b0010, 5'd5, 4'b1000));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int   tries;
        logic timed_out;
        rst        = 1'b1;
        id_valid   = 1'b0;
        inst       = '0;
        pc         = '0;
        rdata1     = '0;
        rdata2     = '0;
        chk_en     = 1'b0;
        exp_stall  = 1'b0;
        exp_ds     = 1'b0;
        exp_br     = '0;
        exp_ctrl   = '0;
        idx        = '0;
        report_req = 1'b0;
        n_entries  = 0;
        timed_out  = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int k = 0; k < n_entries && !timed_out; k++) begin
            id_valid  <= 1'b1;
            inst      <= stim[k].inst;
            pc        <= stim[k].pc;
            rdata1    <= stim[k].rdata1;
            rdata2    <= stim[k].rdata2;
            chk_en    <= 1'b1;
            exp_stall <= stim[k].stall;
            exp_br    <= stim[k].br;
            exp_ds    <= stim[k].ds;
            exp_ctrl  <= stim[k].ctrl;
            idx       <= 8'(k);
            tries = 0;
            @(negedge clk);
            // hold the instruction until the hazard clears
            while (load_stall && !timed_out) begin
                tries++;
                if (tries > 4) begin
                    $display("timeout: load_stall never released");
                    timed_out = 1'b1;
                end else begin
                    @(posedge clk);
                    exp_stall <= 1'b0;
                    @(negedge clk);
                end
            end
            @(posedge clk);
        end
        id_valid <= 1'b0;
        chk_en   <= 1'b0;
        @(posedge clk);
        report_req <= 1'b1;
        tries = 0;
        while (!report_done && !timed_out) begin
            tries++;
            if (tries > 10) begin
                $display("timeout: checker never reported its counts");
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        if (timed_out || errors != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/id_pkg.sv
verilog/inst_recognizer.sv
verilog/ctrl_gen.sv
verilog/branch_unit.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
sim/id_checker.sv
sim/tb_id_stage.sv

//--- run_sim.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_id_stage \
    -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; } ||
{ echo "simulation passed"; exit 0; }
